// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= sfir_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/sfir_tb_model.svh ====
`ifndef SFIR_TB_MODEL_SVH
`define SFIR_TB_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~
// Reference model
// ~~~~~~~~~~~~~~~~~~~~
coef_bank_t                   model_bank;
logic signed [DATA_WIDTH-1:0] history [$];       // One entry per step, oldest first.
int                           steps_since_cfg;

function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
endfunction

// Tap j of the full filter, built from the half bank.
function automatic longint mirrored_coef(input int j);
    if (j < TAP_NUM) begin
        return longint'(model_bank[j]);
    end
    return longint'(model_bank[2*TAP_NUM-1-j]);
endfunction

// Convolution for step k; samples before the first step are zero.
function automatic longint expected_sum(input int k);
    longint acc;
    int     idx;
    acc = 0;
    for (int j = 0; j < 2*TAP_NUM; j++) begin
        idx = k - FIR_LATENCY - j;
        if (idx >= 0) begin
            acc += mirrored_coef(j) * longint'(history[idx]);
        end
    end
    return acc;
endfunction

`endif

// ==== dv/sfir_tb.sv ====
`timescale 1ns/1ns

module sfir_tb
    import sfir_pkg::*;
;

    localparam int          CLK_PERIOD      = 40;
    localparam int          RESET_CYCLES    = 10;
    localparam logic [31:0] SEED            = 32'ha208;
    localparam int          FULL_STEPS      = FIR_LATENCY + 2*TAP_NUM - 1;
    localparam int          IMPULSE_TAIL    = FIR_LATENCY + 2*TAP_NUM;
    localparam int          RANDOM_SAMPLES  = 200;
    localparam int          REWRITE_SAMPLES = 40;
    localparam int          STALL_SAMPLES   = 60;
    localparam int          EXCHANGES       = FULL_STEPS + 1 + IMPULSE_TAIL + RANDOM_SAMPLES
                                              + TAP_NUM + REWRITE_SAMPLES + STALL_SAMPLES;
    localparam int          TIMEOUT_CYCLES  = RESET_CYCLES + 60 * EXCHANGES;

    logic        clk = 1'b0;
    logic        rst;
    logic        sample_req;
    sample_t     sample_data;
    logic        sample_ack;
    logic        result_req;
    fir_result_t result_data;
    logic        result_ack;
    logic        cfg_req;
    coef_wr_t    cfg_wr;
    logic        cfg_ack;

    logic signed [ACC_WIDTH-1:0] exp_sum;
    logic                        exp_primed;
    logic                        sum_known;     // All taps hold real samples.
    logic [31:0]                 rng;
    string                       test_name;
    int                          errors     = 0;
    int                          checked    = 0;
    int                          cfg_writes = 0;

    `include "sfir_tb_model.svh"

    always #(CLK_PERIOD/2) clk = ~clk;

    sfir_systolic_top u_sfir_systolic_top (
        .clk_i       (clk),
        .rst_i       (rst),
        .sample_req_i(sample_req),
        .sample_i    (sample_data),
        .sample_ack_o(sample_ack),
        .result_req_o(result_req),
        .result_o    (result_data),
        .result_ack_i(result_ack),
        .cfg_req_i   (cfg_req),
        .cfg_i       (cfg_wr),
        .cfg_ack_o   (cfg_ack)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Drivers
    // ~~~~~~~~~~~~~~~~~~~~
    task automatic send_sample(input logic signed [DATA_WIDTH-1:0] value, input int ack_delay);
        int   k;
        logic known;
        history.push_back(value);
        k     = history.size() - 1;
        known = (k >= FULL_STEPS) && (steps_since_cfg >= TAP_NUM);
        @(posedge clk);
        sample_data <= '{data: value};
        sample_req  <= 1'b1;
        exp_sum     <= ACC_WIDTH'(expected_sum(k));
        exp_primed  <= (k + 1 >= FULL_STEPS);
        sum_known   <= known;
        steps_since_cfg++;
        checked += int'(known);
        do begin
            @(posedge clk);
        end while (!result_req);
        repeat (ack_delay) @(posedge clk);    // Consumer stall.
        result_ack <= 1'b1;
        do begin
            @(posedge clk);
        end while (!sample_ack);
        sample_req <= 1'b0;
        result_ack <= 1'b0;
        do begin
            @(posedge clk);
        end while (sample_ack);
    endtask

    task automatic write_coef(input logic [COEF_ADDR_WIDTH-1:0] addr, input coef_t value);
        @(posedge clk);
        cfg_wr  <= '{addr: addr, coef: value};
        cfg_req <= 1'b1;
        do begin
            @(posedge clk);
        end while (!cfg_ack);
        cfg_req         <= 1'b0;
        model_bank[addr] = value;
        steps_since_cfg  = 0;                 // Old products drain out of the chain.
        do begin
            @(posedge clk);
        end while (cfg_ack);
        cfg_writes++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~
    sum_match: assert property (@(posedge clk) disable iff (rst)
        result_req && sum_known |-> result_data.sum == exp_sum
    ) else begin
        errors++;
        $display("error %s: expected %0d, actual %0d", test_name,
                 $sampled(exp_sum), $sampled(result_data.sum));
    end

    primed_match: assert property (@(posedge clk) disable iff (rst)
        result_req |-> (exp_primed ? result_data.primed === 1'b1 : result_data.primed !== 1'b1)
    ) else begin
        errors++;
        $display("error %s primed: expected %0b, actual %0b", test_name,
                 $sampled(exp_primed), $sampled(result_data.primed));
    end

    reset_outputs_low: assert property (@(posedge clk)
        $fell(rst) |-> !sample_ack && !result_req && !cfg_ack && !u_sfir_systolic_top.step
    ) else begin
        errors++;
        $display("Outputs were not low after reset");
    end

    ack_after_result: assert property (@(posedge clk) disable iff (rst)
        $rose(sample_ack) |-> $past(result_req && result_ack)
    ) else begin
        errors++;
        $display("Sample ack rose before the result was acknowledged");
    end

    no_ack_while_pending: assert property (@(posedge clk) disable iff (rst)
        result_req |-> !sample_ack
    ) else begin
        errors++;
        $display("Sample ack was high while a result was pending");
    end

    result_held: assert property (@(posedge clk) disable iff (rst)
        result_req && !result_ack |=> result_req && $stable(result_data)
    ) else begin
        errors++;
        $display("Result request or data changed before the ack");
    end

    acks_fall_after_reqs: assert property (@(posedge clk) disable iff (rst)
        (!$fell(sample_ack) || !$past(sample_req)) && (!$fell(cfg_ack) || !$past(cfg_req))
        && (!$fell(result_req) || $past(result_ack))
    ) else begin
        errors++;
        $display("A handshake signal fell before its partner");
    end

    cfg_answered: assert property (@(posedge clk) disable iff (rst)
        cfg_req && !cfg_ack |=> cfg_ack
    ) else begin
        errors++;
        $display("Configuration request was not acknowledged");
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Sequence
    // ~~~~~~~~~~~~~~~~~~~~
    initial begin
        rst             = 1'b1;
        sample_req      = 1'b0;
        sample_data     = '0;
        result_ack      = 1'b0;
        cfg_req         = 1'b0;
        cfg_wr          = '0;
        exp_sum         = '0;
        exp_primed      = 1'b0;
        sum_known       = 1'b0;
        rng             = SEED;
        model_bank      = COEF_INIT;
        steps_since_cfg = TAP_NUM;
        test_name       = "impulse";
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        repeat (FULL_STEPS) send_sample(0, 0);    // Flush the datapath with zeros.
        send_sample(1, 0);
        repeat (IMPULSE_TAIL) send_sample(0, 0);

        test_name = "random";
        repeat (RANDOM_SAMPLES) begin
            rng = xorshift32(rng);
            send_sample(rng[15:0], 0);
        end

        test_name = "coef_rewrite";
        for (int a = 0; a < TAP_NUM; a++) begin
            rng = xorshift32(rng);
            write_coef(COEF_ADDR_WIDTH'(a), rng[15:0]);
        end
        repeat (REWRITE_SAMPLES) begin
            rng = xorshift32(rng);
            send_sample(rng[15:0], 0);
        end

        test_name = "backpressure";
        repeat (STALL_SAMPLES) begin
            rng = xorshift32(rng);
            send_sample(rng[15:0], int'(rng[19:16]));
        end

        @(posedge clk);
        $display("errors: %0d, sums checked: %0d, coefficient writes: %0d",
                 errors, checked, cfg_writes);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, a handshake never completed", TIMEOUT_CYCLES);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== hdl/sfir_coef_regs.sv ====
`timescale 1ns/1ns

module sfir_coef_regs
    import sfir_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       cfg_req_i,
    input  coef_wr_t   cfg_i,
    output logic       cfg_ack_o,
    output coef_bank_t coef_o
);

    // ~~~~~~~~~~~~~~~~~~~~
    // Bank and handshake
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            coef_o    <= COEF_INIT;
            cfg_ack_o <= 1'b0;
        end else begin
            if (cfg_req_i && !cfg_ack_o) begin
                // One write per exchange, seen by the next step.
                coef_o[cfg_i.addr] <= cfg_i.coef;
                cfg_ack_o          <= 1'b1;
            end else if (!cfg_req_i) begin
                cfg_ack_o <= 1'b0;         // Return to zero.
            end
        end
    end

    // Requester keeps req and data steady until ack answers.
    cfg_held: assert property (
        @(posedge clk_i) disable iff (rst_i)
        cfg_req_i && !cfg_ack_o |=> cfg_req_i && $stable(cfg_i)
    );

endmodule

// ==== hdl/sfir_pkg.sv ====
package sfir_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Filter sizes
    // ~~~~~~~~~~~~~~~~~~~~
    localparam int TAP_NUM         = 8;                  // Systolic elements, 16 taps.
    localparam int DATA_WIDTH      = 16;
    localparam int COEF_WIDTH      = 16;
    localparam int PREADD_WIDTH    = DATA_WIDTH + 1;
    localparam int PROD_WIDTH      = PREADD_WIDTH + COEF_WIDTH;
    localparam int ACC_WIDTH       = PROD_WIDTH + $clog2(TAP_NUM);
    localparam int FIR_LATENCY     = TAP_NUM + 3;        // Steps until first contribution.
    localparam int COEF_ADDR_WIDTH = 3;

    // Mirror line spans all 16 taps. Primed line counts steps until the pipeline is full.
    localparam int SAMPLE_DELAY = 2 * TAP_NUM;
    localparam int PRIMED_DELAY = FIR_LATENCY + 2 * TAP_NUM - 1;

    typedef logic [$clog2(SAMPLE_DELAY)-1:0] sample_sel_t;
    typedef logic [$clog2(PRIMED_DELAY)-1:0] primed_sel_t;

    localparam sample_sel_t SAMPLE_SEL = sample_sel_t'(SAMPLE_DELAY - 1);
    localparam primed_sel_t PRIMED_SEL = primed_sel_t'(PRIMED_DELAY - 1);

    // ~~~~~~~~~~~~~~~~~~~~
    // Coefficients
    // ~~~~~~~~~~~~~~~~~~~~
    typedef logic signed [COEF_WIDTH-1:0] coef_t;
    typedef coef_t [0:TAP_NUM-1] coef_bank_t;

    // Low-pass half, outer taps first.
    localparam coef_bank_t COEF_INIT = {
        coef_t'(-21), coef_t'(-48), coef_t'(-37), coef_t'(72),
        coef_t'(310), coef_t'(655), coef_t'(1004), coef_t'(1232)
    };

    // ~~~~~~~~~~~~~~~~~~~~
    // Payloads
    // ~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic signed [DATA_WIDTH-1:0] data;
    } sample_t;

    typedef struct packed {
        logic                        primed;  // Pipeline was full.
        logic signed [ACC_WIDTH-1:0] sum;
    } fir_result_t;

    typedef struct packed {
        logic [COEF_ADDR_WIDTH-1:0] addr;
        coef_t                      coef;
    } coef_wr_t;

endpackage

// ==== hdl/sfir_stream_ctrl.sv ====
`timescale 1ns/1ns

module sfir_stream_ctrl
    import sfir_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        sample_req_i,
    input  sample_t     sample_i,
    output logic        sample_ack_o,
    output logic        step_o,
    output sample_t     sample_q_o,
    input  fir_result_t fir_i,
    output logic        result_req_o,
    output fir_result_t result_o,
    input  logic        result_ack_i
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_STEP,
        ST_CAPTURE,
        ST_WAIT_ACK,
        ST_RELEASE
    } state_e;

    state_e state_q;

    // ~~~~~~~~~~~~~~~~~~~~
    // FSM
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q      <= ST_IDLE;
            sample_ack_o <= 1'b0;
            result_req_o <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (sample_req_i) begin
                        state_q <= ST_STEP;
                    end
                end
                ST_STEP: begin
                    state_q <= ST_CAPTURE;     // Elements update on this edge.
                end
                ST_CAPTURE: begin
                    result_req_o <= 1'b1;
                    state_q      <= ST_WAIT_ACK;
                end
                ST_WAIT_ACK: begin
                    if (result_ack_i) begin
                        result_req_o <= 1'b0;
                        sample_ack_o <= 1'b1;  // Sample is only released once the result is taken.
                        state_q      <= ST_RELEASE;
                    end
                end
                ST_RELEASE: begin
                    // Both channels back to zero before the next sample.
                    if (!sample_req_i && !result_ack_i) begin
                        sample_ack_o <= 1'b0;
                        state_q      <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    assign step_o = (state_q == ST_STEP);

    // Sample and result holding registers.
    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && sample_req_i) begin
            sample_q_o <= sample_i;
        end
        if (state_q == ST_CAPTURE) begin
            result_o <= fir_i;
        end
    end

    // No datapath step while a result is still offered.
    no_step_pending: assert property (
        @(posedge clk_i) disable iff (rst_i)
        $rose(step_o) |-> !result_req_o
    );

    // Offered result stays put until the consumer acknowledges.
    result_held: assert property (
        @(posedge clk_i) disable iff (rst_i)
        result_req_o && !result_ack_i |=> result_req_o && $stable(result_o)
    );

endmodule

// ==== hdl/sfir_systolic_element.sv ====
`timescale 1ns/1ns

module sfir_systolic_element
    import sfir_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        en_i,
    input  logic signed [COEF_WIDTH-1:0] coeff_i,
    input  sample_t                     data_i,
    input  sample_t                     dataz_i,
    input  logic signed [ACC_WIDTH-1:0] casc_i,
    output sample_t                     cascdata_o,
    output logic signed [ACC_WIDTH-1:0] casc_o
);

    sample_t                         fwd_q;
    sample_t                         fwd_qq;
    sample_t                         mirror_q;
    logic signed [PREADD_WIDTH-1:0]  preadd_q;
    logic signed [PROD_WIDTH-1:0]    prod_q;

    // ~~~~~~~~~~~~~~~~~~~~
    // Forward and mirror
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            fwd_q    <= data_i;
            fwd_qq   <= fwd_q;     // Two steps per element.
            mirror_q <= dataz_i;
        end
    end

    assign cascdata_o = fwd_qq;

    // ~~~~~~~~~~~~~~~~~~~~
    // Arithmetic
    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            preadd_q <= PREADD_WIDTH'(fwd_qq.data) + PREADD_WIDTH'(mirror_q.data);
            prod_q   <= PROD_WIDTH'(preadd_q) * PROD_WIDTH'(coeff_i);
            casc_o   <= casc_i + ACC_WIDTH'(prod_q);
        end
    end

endmodule

// ==== hdl/sfir_systolic_top.sv ====
`timescale 1ns/1ns

module sfir_systolic_top
    import sfir_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,

    input  logic        sample_req_i,
    input  sample_t     sample_i,
    output logic        sample_ack_o,

    output logic        result_req_o,
    output fir_result_t result_o,
    input  logic        result_ack_i,

    input  logic        cfg_req_i,
    input  coef_wr_t    cfg_i,
    output logic        cfg_ack_o
);

    logic                        step;
    sample_t                     sample_q;
    sample_t                     sample_mirror;
    logic                        primed;
    coef_bank_t                  coef;
    fir_result_t                 fir;
    sample_t                     fwd  [TAP_NUM+1];
    logic signed [ACC_WIDTH-1:0] casc [TAP_NUM+1];

    // ~~~~~~~~~~~~~~~~~~~~
    // Control
    // ~~~~~~~~~~~~~~~~~~~~
    sfir_stream_ctrl u_sfir_stream_ctrl (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .sample_req_i(sample_req_i),
        .sample_i    (sample_i),
        .sample_ack_o(sample_ack_o),
        .step_o      (step),
        .sample_q_o  (sample_q),
        .fir_i       (fir),
        .result_req_o(result_req_o),
        .result_o    (result_o),
        .result_ack_i(result_ack_i)
    );

    sfir_coef_regs u_sfir_coef_regs (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .cfg_req_i(cfg_req_i),
        .cfg_i    (cfg_i),
        .cfg_ack_o(cfg_ack_o),
        .coef_o   (coef)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Delay lines
    // ~~~~~~~~~~~~~~~~~~~~
    shift_reg #(
        .T    (sample_t),
        .DELAY(SAMPLE_DELAY)
    ) u_sample_dly (
        .clk_i (clk_i),
        .en_i  (step),
        .sel_i (SAMPLE_SEL),
        .data_i(sample_q),
        .data_o(sample_mirror)
    );

    // Ones fill in behind each step.
    shift_reg #(
        .T    (logic),
        .DELAY(PRIMED_DELAY)
    ) u_primed_dly (
        .clk_i (clk_i),
        .en_i  (step),
        .sel_i (PRIMED_SEL),
        .data_i(1'b1),
        .data_o(primed)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Element chain
    // ~~~~~~~~~~~~~~~~~~~~
    assign fwd[0]  = sample_q;
    assign casc[0] = '0;

    for (genvar i = 0; i < TAP_NUM; i++) begin : g_tap
        sfir_systolic_element u_element (
            .clk_i     (clk_i),
            .en_i      (step),
            .coeff_i   (coef[i]),
            .data_i    (fwd[i]),
            .dataz_i   (sample_mirror),
            .casc_i    (casc[i]),
            .cascdata_o(fwd[i+1]),
            .casc_o    (casc[i+1])
        );
    end

    assign fir = '{primed: primed, sum: casc[TAP_NUM]};

endmodule

// ==== hdl/shift_reg.sv ====
`timescale 1ns/1ns

module shift_reg #(
    parameter type T     = logic,
    parameter int  DELAY = 2
) (
    input  logic                     clk_i,
    input  logic                     en_i,
    input  logic [$clog2(DELAY)-1:0] sel_i,
    input  T                         data_i,
    output T                         data_o
);

    T stage [DELAY];

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            stage[0] <= data_i;
            for (int i = 1; i < DELAY; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign data_o = stage[sel_i];  // Depth sel_i + 1 steps.

    // Tap select comes from the parent and must stay inside the chain.
    sel_in_range: assert property (
        @(posedge clk_i) int'(sel_i) < DELAY
    );

endmodule

// ==== sources.f ====
+incdir+dv
hdl/sfir_pkg.sv
hdl/shift_reg.sv
hdl/sfir_systolic_element.sv
hdl/sfir_coef_regs.sv
hdl/sfir_stream_ctrl.sv
hdl/sfir_systolic_top.sv
dv/sfir_tb.sv
